// File: project.f
logic/tg_pkg.sv
logic/tg_cmd_fifo.sv
logic/tg_cmd_sequencer.sv
logic/tg_avl_master.sv
logic/tg_data_gen.sv
logic/tg_top.sv
tb/tg_assert.sv
tb/tg_tb.sv

// File: Makefile
# Verilator build and run for the Avalon-MM traffic generator

VERILATOR ?= verilator
TOP       ?= tg_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert --timing -j 0
LINTFLAGS ?= --lint-only --assert --timing
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: tb/tg_tb.sv
/*
 * Traffic generator testbench
 * Drives start and a pseudo-random avl_ready, models the memory behind
 * the Avalon port, and checks every request and the final memory
 * contents against a model of the burst program and the LFSR sequences
 */
`timescale 1ns/1ps
`default_nettype none

module tg_tb import tg_pkg::*; ();

   localparam int          CLK_PERIOD      = 40;
   localparam int          WATCHDOG_CYCLES = TG_NUM_BURSTS * 3 * TG_MAX_BURST * 4;
   localparam int          MEM_WORDS       = 1 << TG_ADDR_WIDTH;
   localparam logic [31:0] LCG_SEED        = 32'd75;

   typedef enum logic [1:0] {
      BEAT_NORMAL,
      BEAT_INVERSE,
      BEAT_READ
   } beat_kind_t;

   // Expected request together with its place in the program
   typedef struct packed {
      tg_avl_req_t req;
      beat_kind_t  kind;
      logic [7:0]  burst;
      logic [3:0]  beat;
   } exp_req_t;

   logic        clk;
   logic        reset_n;
   logic        start;
   logic        avl_ready;
   tg_avl_req_t avl_req;
   logic        done;

   exp_req_t    exp_list [$];
   logic [31:0] exp_mem [MEM_WORDS];
   logic [31:0] mem [MEM_WORDS];
   int          exp_idx      = 0;
   int          write_beats  = 0;
   int          reads_logged = 0;
   int          checks_done  = 0;
   int          value_errors = 0;
   int          other_errors = 0;

   tg_top u_tg_top (
      .clk       (clk),
      .reset_n   (reset_n),
      .start     (start),
      .avl_ready (avl_ready),
      .avl_req   (avl_req),
      .done      (done)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   //////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////
   // Sizes run 1..8 and repeat
   function automatic int burst_size(input int n);
      return n % TG_MAX_BURST + 1;
   endfunction

   // Bursts sit back to back from address zero
   function automatic int burst_addr(input int n);
      int sum;
      sum = 0;
      for (int k = 0; k < n; k++) begin
         sum += burst_size(k);
      end
      return sum;
   endfunction

   // One Galois step where the bit shifted out feeds taps 32, 22, 2 and 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      logic [31:0] n;
      logic        fb;
      fb    = s[0];
      n     = {1'b0, s[31:1]};
      n[31] = fb;
      n[21] = n[21] ^ fb;
      n[1]  = n[1] ^ fb;
      n[0]  = n[0] ^ fb;
      return n;
   endfunction

   // Word left after a write and its inverse pass
   function automatic logic [31:0] masked_word(input logic [31:0] data, input logic [3:0] be);
      logic [31:0] w;
      for (int b = 0; b < 4; b++) begin
         w[8*b +: 8] = be[b] ? data[8*b +: 8] : 8'h00;
      end
      return w;
   endfunction

   function automatic logic [31:0] fill_pattern(input int addr);
      logic [11:0] a;
      a = addr[11:0];
      return {4'hC, a, 4'h3, ~a};
   endfunction

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   function automatic string kind_label(input beat_kind_t kind);
      case (kind)
         BEAT_NORMAL:  return "write";
         BEAT_INVERSE: return "inverse";
         default:      return "read";
      endcase
   endfunction

   // Whole request stream and final memory image of the program
   task automatic build_expected();
      logic [31:0] wdata_state;
      logic [31:0] be_state;
      logic [3:0]  be_of_beat [TG_MAX_BURST];
      exp_req_t    e;
      int          addr;
      int          size;
      wdata_state = TG_LFSR_SEED;
      be_state    = TG_LFSR_SEED;
      for (int w = 0; w < MEM_WORDS; w++) begin
         exp_mem[w] = fill_pattern(w);
      end
      for (int n = 0; n < TG_NUM_BURSTS; n++) begin
         addr           = burst_addr(n);
         size           = burst_size(n);
         e              = '0;
         e.req.addr     = TG_ADDR_WIDTH'(addr);
         e.req.size     = TG_SIZE_WIDTH'(size);
         e.burst        = 8'(n);
         e.req.write_req = 1'b1;
         for (int j = 0; j < size; j++) begin
            e.kind        = BEAT_NORMAL;
            e.beat        = 4'(j);
            e.req.wdata   = wdata_state;
            e.req.be      = be_state[3:0];
            be_of_beat[j] = be_state[3:0];
            exp_mem[addr + j] = masked_word(wdata_state, be_state[3:0]);
            exp_list.push_back(e);
            wdata_state = lfsr_step(wdata_state);
            be_state    = lfsr_step(be_state);
         end
         // Inverse pass clears the bytes its write pass left alone
         for (int j = 0; j < size; j++) begin
            e.kind      = BEAT_INVERSE;
            e.beat      = 4'(j);
            e.req.wdata = '0;
            e.req.be    = ~be_of_beat[j];
            exp_list.push_back(e);
         end
         e.kind          = BEAT_READ;
         e.beat          = '0;
         e.req.write_req = 1'b0;
         e.req.read_req  = 1'b1;
         e.req.wdata     = '0;
         e.req.be        = '0;
         exp_list.push_back(e);
      end
   endtask

   task automatic check_field(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks_done++;
      assert (actual === expected) else begin
         value_errors++;
         $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
      end
   endtask

   task automatic print_counts();
      $display("Checks run: %0d, value errors: %0d, other errors: %0d",
               checks_done, value_errors, other_errors);
   endtask

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////
   // About a third of the cycles stall and a long stall comes every 160 cycles
   initial begin : drive_ready
      logic [31:0] lcg_state;
      int          cycle;
      int          roll;
      lcg_state = LCG_SEED;
      cycle     = 0;
      avl_ready = 1'b0;
      @(posedge reset_n);
      forever begin
         @(negedge clk);
         lcg_state = lcg_next(lcg_state);
         roll      = int'(lcg_state[23:16]) % 3;
         cycle++;
         if (cycle % 160 >= 120) begin
            avl_ready = 1'b0;
         end else begin
            avl_ready = (roll != 0);
         end
      end
   end

   // The memory behind the port takes a request on an edge with avl_ready high
   initial begin : memory_model
      int waddr;
      int beat_idx;
      beat_idx = 0;
      for (int w = 0; w < MEM_WORDS; w++) begin
         mem[w] = fill_pattern(w);
      end
      forever begin
         @(posedge clk);
         if (reset_n && avl_ready) begin
            if (avl_req.write_req) begin
               // Beats of a burst land on consecutive words
               waddr = (int'(avl_req.addr) + beat_idx) % MEM_WORDS;
               for (int b = 0; b < 4; b++) begin
                  if (avl_req.be[b]) begin
                     mem[waddr][8*b +: 8] = avl_req.wdata[8*b +: 8];
                  end
               end
               beat_idx = (beat_idx + 1 == int'(avl_req.size)) ? 0 : beat_idx + 1;
            end else if (avl_req.read_req) begin
               reads_logged++;
            end
         end
      end
   end

   // Every taken request against the next entry of the expected stream
   initial begin : compare_requests
      exp_req_t e;
      string    tag;
      forever begin
         @(posedge clk);
         if (reset_n && avl_ready && (avl_req.write_req || avl_req.read_req)) begin
            if (avl_req.write_req) begin
               write_beats++;
            end
            assert (exp_idx < exp_list.size()) else begin
               other_errors++;
               $display("Unexpected request after the whole program was issued, addr %0h",
                        avl_req.addr);
            end
            if (exp_idx < exp_list.size()) begin
               e = exp_list[exp_idx];
               exp_idx++;
               tag = $sformatf("burst %0d %s beat %0d", e.burst, kind_label(e.kind), e.beat);
               check_field({tag, " write_req"}, 32'(e.req.write_req), 32'(avl_req.write_req));
               check_field({tag, " read_req"}, 32'(e.req.read_req), 32'(avl_req.read_req));
               check_field({tag, " addr"}, 32'(e.req.addr), 32'(avl_req.addr));
               check_field({tag, " size"}, 32'(e.req.size), 32'(avl_req.size));
               if (e.kind != BEAT_READ) begin
                  check_field({tag, " wdata"}, e.req.wdata, avl_req.wdata);
                  check_field({tag, " be"}, 32'(e.req.be), 32'(avl_req.be));
               end
            end
         end
      end
   end

   initial begin : main_sequence
      reset_n = 1'b0;
      start   = 1'b0;
      build_expected();
      repeat (2) @(negedge clk);
      reset_n = 1'b1;
      check_field("reset done", 32'd0, 32'(done));
      check_field("reset write_req", 32'd0, 32'(avl_req.write_req));
      @(negedge clk);
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
      while (done !== 1'b1) @(negedge clk);
      // Reads still in the FIFO drain after done
      while (reads_logged < TG_NUM_BURSTS) @(negedge clk);
      check_field("done held", 32'd1, 32'(done));
      check_field("requests issued", exp_list.size(), exp_idx);
      check_field("write beats", 2 * burst_addr(TG_NUM_BURSTS), write_beats);
      for (int w = 0; w < MEM_WORDS; w++) begin
         check_field($sformatf("memory word %0h", w), exp_mem[w], mem[w]);
      end
      print_counts();
      if (value_errors == 0 && other_errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

   initial begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Timeout: the program did not finish within %0d cycles", WATCHDOG_CYCLES);
      print_counts();
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: tb/tg_assert.sv
/*
 * Avalon request checks
 * Bound into the Avalon master. Request fields hold while avl_ready is
 * low, write and read never overlap, and both are quiet after reset
 */
`timescale 1ns/1ps
`default_nettype none

module tg_assert import tg_pkg::*; (
   input logic        clk,
   input logic        reset_n,
   input logic        avl_ready,
   input tg_avl_req_t avl_req
);

   logic req_active;

   assign req_active = avl_req.write_req | avl_req.read_req;

   // Strobes never move while the slave stalls
   a_strobes_hold: assert property (@(posedge clk) disable iff (!reset_n)
      !avl_ready |=> $stable(avl_req.write_req) && $stable(avl_req.read_req))
      else $error("request strobes changed while avl_ready was low");

   // A pending request keeps every field until it is taken
   a_fields_hold: assert property (@(posedge clk) disable iff (!reset_n)
      (!avl_ready && req_active) |=> $stable(avl_req))
      else $error("request fields changed while avl_ready was low");

   a_no_overlap: assert property (@(posedge clk) disable iff (!reset_n)
      !(avl_req.write_req && avl_req.read_req))
      else $error("write_req and read_req were high together");

   a_quiet_after_reset: assert property (@(posedge clk)
      !reset_n |=> !avl_req.write_req && !avl_req.read_req)
      else $error("a request was active in the cycle after reset");

endmodule

bind tg_avl_master tg_assert u_tg_assert (
   .clk       (clk),
   .reset_n   (reset_n),
   .avl_ready (avl_ready),
   .avl_req   (avl_req)
);

`default_nettype wire

// File: logic/tg_top.sv
/*
 * Traffic generator top level
 * Connects the command sequencer, the Avalon master and the data
 * generator to the Avalon-MM request port
 */
`timescale 1ns/1ps
`default_nettype none

module tg_top import tg_pkg::*; (
   input  logic        clk,
   input  logic        reset_n,
   input  logic        start,
   input  logic        avl_ready,
   output tg_avl_req_t avl_req,
   output logic        done
);

   // Sequencer to master
   logic    do_write;
   logic    do_inv_be_write;
   logic    do_read;
   tg_cmd_t write_cmd;
   tg_cmd_t read_cmd;
   logic    ready;

   // Master to data generator
   logic                     wdata_gen_enable;
   logic                     inv_be_gen_enable;
   logic [TG_DATA_WIDTH-1:0] wdata;
   logic [TG_BE_WIDTH-1:0]   be;
   logic [TG_BE_WIDTH-1:0]   inv_be;

   tg_cmd_sequencer u_sequencer (
      .clk             (clk),
      .reset_n         (reset_n),
      .start           (start),
      .ready           (ready),
      .do_write        (do_write),
      .do_inv_be_write (do_inv_be_write),
      .do_read         (do_read),
      .write_cmd       (write_cmd),
      .read_cmd        (read_cmd),
      .done            (done)
   );

   tg_avl_master u_avl_master (
      .clk               (clk),
      .reset_n           (reset_n),
      .avl_ready         (avl_ready),
      .avl_req           (avl_req),
      .do_write          (do_write),
      .do_inv_be_write   (do_inv_be_write),
      .do_read           (do_read),
      .write_cmd         (write_cmd),
      .read_cmd          (read_cmd),
      .ready             (ready),
      .wdata             (wdata),
      .be                (be),
      .inv_be            (inv_be),
      .wdata_gen_enable  (wdata_gen_enable),
      .inv_be_gen_enable (inv_be_gen_enable)
   );

   tg_data_gen u_data_gen (
      .clk               (clk),
      .reset_n           (reset_n),
      .wdata_gen_enable  (wdata_gen_enable),
      .inv_be_gen_enable (inv_be_gen_enable),
      .wdata             (wdata),
      .be                (be),
      .inv_be            (inv_be)
   );

endmodule

`default_nettype wire

// File: logic/tg_data_gen.sv
/*
 * Write data generator
 * Three Galois LFSRs with a common seed supply write data, byte enables
 * and inverse byte enables. The inverse LFSR replays the byte-enable
 * sequence, so each inverse pass complements its own write pass
 */
`timescale 1ns/1ps
`default_nettype none

module tg_data_gen import tg_pkg::*; (
   input  logic                     clk,
   input  logic                     reset_n,
   input  logic                     wdata_gen_enable,
   input  logic                     inv_be_gen_enable,
   output logic [TG_DATA_WIDTH-1:0] wdata,
   output logic [TG_BE_WIDTH-1:0]   be,
   output logic [TG_BE_WIDTH-1:0]   inv_be
);

   logic [TG_DATA_WIDTH-1:0] wdata_lfsr;
   logic [TG_DATA_WIDTH-1:0] be_lfsr;
   logic [TG_DATA_WIDTH-1:0] inv_be_lfsr;

   // Current values are used first, the step happens on the same edge
   assign wdata  = wdata_lfsr;
   assign be     = be_lfsr[TG_BE_WIDTH-1:0];
   assign inv_be = ~inv_be_lfsr[TG_BE_WIDTH-1:0];

   //////////////////////////////////////////////////
   // LFSR state
   //////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         wdata_lfsr  <= TG_LFSR_SEED;
         be_lfsr     <= TG_LFSR_SEED;
         inv_be_lfsr <= TG_LFSR_SEED;
      end else begin
         // Data and byte enables move together on normal write beats
         if (wdata_gen_enable) begin
            wdata_lfsr <= tg_lfsr_next(wdata_lfsr);
            be_lfsr    <= tg_lfsr_next(be_lfsr);
         end
         // Inverse beats walk their own copy of the byte-enable sequence
         if (inv_be_gen_enable) begin
            inv_be_lfsr <= tg_lfsr_next(inv_be_lfsr);
         end
      end
   end

endmodule

`default_nettype wire

// File: logic/tg_avl_master.sv
/*
 * Avalon-MM master
 * Registers the sequencer strobes, expands each write burst into one
 * FIFO entry per beat and turns the FIFO head into registered Avalon
 * requests. Request fields only change while avl_ready is high
 */
`timescale 1ns/1ps
`default_nettype none

module tg_avl_master import tg_pkg::*; (
   input  logic                     clk,
   input  logic                     reset_n,
   input  logic                     avl_ready,
   output tg_avl_req_t              avl_req,
   input  logic                     do_write,
   input  logic                     do_inv_be_write,
   input  logic                     do_read,
   input  tg_cmd_t                  write_cmd,
   input  tg_cmd_t                  read_cmd,
   output logic                     ready,
   input  logic [TG_DATA_WIDTH-1:0] wdata,
   input  logic [TG_BE_WIDTH-1:0]   be,
   input  logic [TG_BE_WIDTH-1:0]   inv_be,
   output logic                     wdata_gen_enable,
   output logic                     inv_be_gen_enable
);

   typedef enum logic [1:0] {
      IDLE,
      WRITE_BURST,
      INV_WRITE_BURST
   } state_t;

   state_t                   state;
   logic [TG_SIZE_WIDTH-1:0] burst_counter;

   // Accepted strobes and their command fields
   logic    do_write_r;
   logic    do_inv_be_write_r;
   logic    do_read_r;
   logic    any_cmd_r;
   tg_cmd_t write_cmd_r;
   tg_cmd_t read_cmd_r;
   // Address and size of the burst being expanded
   tg_cmd_t last_write_cmd_r;

   // FIFO side
   logic        fifo_push;
   logic        fifo_pop;
   tg_cmd_t     fifo_din;
   tg_cmd_t     fifo_dout;
   logic        fifo_full;
   logic        fifo_empty;
   tg_avl_req_t req_next;

   assign any_cmd_r = do_write_r | do_inv_be_write_r | do_read_r;

   tg_cmd_fifo u_cmd_fifo (
      .clk     (clk),
      .reset_n (reset_n),
      .push    (fifo_push),
      .pop     (fifo_pop),
      .din     (fifo_din),
      .dout    (fifo_dout),
      .full    (fifo_full),
      .empty   (fifo_empty)
   );

   //////////////////////////////////////////////////
   // Strobe capture
   //////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         do_write_r        <= 1'b0;
         do_inv_be_write_r <= 1'b0;
         do_read_r         <= 1'b0;
      end else if (ready) begin
         do_write_r        <= do_write;
         do_inv_be_write_r <= do_inv_be_write;
         do_read_r         <= do_read;
      end
   end

   always_ff @(posedge clk) begin
      if (ready) begin
         write_cmd_r <= write_cmd;
         read_cmd_r  <= read_cmd;
      end
      // Remember the burst fields when its first beat is queued
      if (!fifo_full && state == IDLE && (do_write_r || do_inv_be_write_r))
         last_write_cmd_r <= write_cmd_r;
   end

   //////////////////////////////////////////////////
   // Burst expansion FSM
   //////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state         <= IDLE;
         burst_counter <= '0;
      end else if (!fifo_full) begin
         case (state)
            IDLE: begin
               if (do_write_r || do_inv_be_write_r) begin
                  // First beat goes in now, the rest are counted here
                  burst_counter <= write_cmd_r.size - 1'b1;
                  if (write_cmd_r.size > TG_SIZE_WIDTH'(1))
                     state <= do_write_r ? WRITE_BURST : INV_WRITE_BURST;
               end
            end
            default: begin
               burst_counter <= burst_counter - 1'b1;
               if (burst_counter == TG_SIZE_WIDTH'(1)) state <= IDLE;
            end
         endcase
      end
   end

   // FIFO entry and ready generation
   always_comb begin
      ready                = 1'b0;
      fifo_push            = 1'b0;
      fifo_din             = last_write_cmd_r;
      fifo_din.is_write    = 1'b0;
      fifo_din.use_inv_be  = 1'b0;
      if (!fifo_full) begin
         if (state == IDLE) begin
            // Any pending command leaves this cycle, so a new one fits
            ready = 1'b1;
            if (do_write_r || do_inv_be_write_r) begin
               fifo_push           = 1'b1;
               fifo_din            = write_cmd_r;
               fifo_din.is_write   = 1'b1;
               fifo_din.use_inv_be = do_inv_be_write_r;
            end else if (do_read_r) begin
               fifo_push           = 1'b1;
               fifo_din            = read_cmd_r;
               fifo_din.is_write   = 1'b0;
               fifo_din.use_inv_be = 1'b0;
            end
         end else begin
            // Remaining beats reuse the stored address and size
            ready               = ~any_cmd_r;
            fifo_push           = 1'b1;
            fifo_din.is_write   = 1'b1;
            fifo_din.use_inv_be = (state == INV_WRITE_BURST);
         end
      end else begin
         ready = ~any_cmd_r;
      end
   end

   //////////////////////////////////////////////////
   // Avalon request stage
   //////////////////////////////////////////////////
   assign fifo_pop = avl_ready & ~fifo_empty;

   // Inverse beats write zero data under the complemented byte enables
   always_comb begin
      req_next.write_req = ~fifo_empty & fifo_dout.is_write;
      req_next.read_req  = ~fifo_empty & ~fifo_dout.is_write;
      req_next.addr      = fifo_dout.addr;
      req_next.size      = fifo_dout.size;
      req_next.wdata     = fifo_dout.use_inv_be ? '0 : wdata;
      req_next.be        = fifo_dout.use_inv_be ? inv_be : be;
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         avl_req.write_req <= 1'b0;
         avl_req.read_req  <= 1'b0;
      end else if (avl_ready) begin
         avl_req <= req_next;
      end
   end

   // Step the generators on each beat that is actually taken
   assign wdata_gen_enable  = fifo_pop & fifo_dout.is_write & ~fifo_dout.use_inv_be;
   assign inv_be_gen_enable = fifo_pop & fifo_dout.is_write & fifo_dout.use_inv_be;

endmodule

`default_nettype wire

// File: logic/tg_cmd_sequencer.sv
/*
 * Command sequencer
 * Walks the fixed burst program and, for every burst, strobes a write,
 * then an inverse byte-enable write, then a read at the same address
 * and size. Raises done once the final read has been taken
 */
`timescale 1ns/1ps
`default_nettype none

module tg_cmd_sequencer import tg_pkg::*; (
   input  logic    clk,
   input  logic    reset_n,
   input  logic    start,
   input  logic    ready,
   output logic    do_write,
   output logic    do_inv_be_write,
   output logic    do_read,
   output tg_cmd_t write_cmd,
   output tg_cmd_t read_cmd,
   output logic    done
);

   // One phase per command of a burst, plus waiting and finished states
   typedef enum logic [2:0] {
      S_IDLE,
      S_WRITE,
      S_INV,
      S_READ,
      S_DONE
   } seq_state_t;

   seq_state_t                    state;
   logic [TG_ADDR_WIDTH-1:0]      addr_q;
   logic [TG_SIZE_WIDTH-1:0]      size_q;
   logic [TG_BURST_IDX_WIDTH-1:0] burst_idx;
   logic                          last_burst;

   assign last_burst = (burst_idx == TG_BURST_IDX_WIDTH'(TG_NUM_BURSTS - 1));

   // Strobes follow the phase directly
   // A phase only moves on when ready is high, so a stalled strobe holds
   assign do_write        = (state == S_WRITE);
   assign do_inv_be_write = (state == S_INV);
   assign do_read         = (state == S_READ);

   // Both the write and the inverse pass use the same command fields
   assign write_cmd = '{is_write:   1'b1,
                        use_inv_be: (state == S_INV),
                        addr:       addr_q,
                        size:       size_q};

   assign read_cmd = '{is_write:   1'b0,
                       use_inv_be: 1'b0,
                       addr:       addr_q,
                       size:       size_q};

   //////////////////////////////////////////////////
   // Program walk
   //////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state     <= S_IDLE;
         addr_q    <= '0;
         size_q    <= TG_SIZE_WIDTH'(1);
         burst_idx <= '0;
         done      <= 1'b0;
      end else begin
         case (state)
            S_IDLE: begin
               if (start) state <= S_WRITE;
            end
            S_WRITE: begin
               if (ready) state <= S_INV;
            end
            S_INV: begin
               if (ready) state <= S_READ;
            end
            S_READ: begin
               if (ready) begin
                  if (last_burst) begin
                     state <= S_DONE;
                     done  <= 1'b1;
                  end else begin
                     // Next burst starts right after this one in memory
                     addr_q    <= addr_q + TG_ADDR_WIDTH'(size_q);
                     // Sizes cycle 1..TG_MAX_BURST
                     size_q    <= (size_q == TG_SIZE_WIDTH'(TG_MAX_BURST)) ?
                                  TG_SIZE_WIDTH'(1) : size_q + 1'b1;
                     burst_idx <= burst_idx + 1'b1;
                     state     <= S_WRITE;
                  end
               end
            end
            // Program finished, done stays up until reset
            default: state <= S_DONE;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: logic/tg_cmd_fifo.sv
/*
 * Show-ahead command FIFO
 * Register-array FIFO of TG_FIFO_DEPTH command entries. The head entry
 * is always visible on dout while the FIFO is not empty
 */
`timescale 1ns/1ps
`default_nettype none

module tg_cmd_fifo import tg_pkg::*; (
   input  logic    clk,
   input  logic    reset_n,
   input  logic    push,
   input  logic    pop,
   input  tg_cmd_t din,
   output tg_cmd_t dout,
   output logic    full,
   output logic    empty
);

   tg_cmd_t                      mem [TG_FIFO_DEPTH];
   logic [TG_FIFO_PTR_WIDTH-1:0] rd_ptr;
   logic [TG_FIFO_PTR_WIDTH-1:0] wr_ptr;
   logic [TG_FIFO_PTR_WIDTH:0]   count;
   logic                         do_push;
   logic                         do_pop;

   // Ignore a push into a full FIFO and a pop from an empty one
   assign do_push = push & ~full;
   assign do_pop  = pop & ~empty;

   assign full  = (count == (TG_FIFO_PTR_WIDTH + 1)'(TG_FIFO_DEPTH));
   assign empty = (count == '0);

   // Head entry shown without waiting for a pop
   assign dout = mem[rd_ptr];

   // Storage array
   always_ff @(posedge clk) begin
      if (do_push) mem[wr_ptr] <= din;
   end

   // Pointers and occupancy
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
         // Simultaneous push and pop leaves occupancy unchanged
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: logic/tg_pkg.sv
/*
 * Traffic generator shared definitions
 * Fixed bus widths, the burst program constants, the LFSR seed and taps,
 * the command FIFO entry and the registered Avalon-MM request bundle
 */
`default_nettype none

package tg_pkg;

   //////////////////////////////////////////////////
   // Bus widths
   //////////////////////////////////////////////////
   localparam int TG_ADDR_WIDTH = 12;
   localparam int TG_SIZE_WIDTH = 4;
   localparam int TG_DATA_WIDTH = 32;
   localparam int TG_BE_WIDTH   = 4;

   // Burst program shape
   localparam int TG_MAX_BURST       = 8;
   localparam int TG_NUM_BURSTS      = 24;
   localparam int TG_BURST_IDX_WIDTH = 5;

   // Command FIFO geometry, depth is a power of two so pointers wrap naturally
   localparam int TG_FIFO_DEPTH     = 8;
   localparam int TG_FIFO_PTR_WIDTH = 3;

   // Galois LFSR, taps 32, 22, 2 and 1 folded into a right-shift mask
   localparam logic [TG_DATA_WIDTH-1:0] TG_LFSR_SEED = 32'hACE1_2468;
   localparam logic [TG_DATA_WIDTH-1:0] TG_LFSR_TAPS = 32'h8020_0003;

   //////////////////////////////////////////////////
   // Command FIFO entry, one per Avalon beat or read
   //////////////////////////////////////////////////
   typedef struct packed {
      logic                     is_write;
      logic                     use_inv_be;
      logic [TG_ADDR_WIDTH-1:0] addr;
      logic [TG_SIZE_WIDTH-1:0] size;
   } tg_cmd_t;

   // Avalon-MM request signals as driven by the master
   typedef struct packed {
      logic                     write_req;
      logic                     read_req;
      logic [TG_ADDR_WIDTH-1:0] addr;
      logic [TG_SIZE_WIDTH-1:0] size;
      logic [TG_DATA_WIDTH-1:0] wdata;
      logic [TG_BE_WIDTH-1:0]   be;
   } tg_avl_req_t;

   // One step of the LFSR
   // The state shifts right and the mask is applied when a one falls out
   function automatic logic [TG_DATA_WIDTH-1:0] tg_lfsr_next(
      input logic [TG_DATA_WIDTH-1:0] state
   );
      logic [TG_DATA_WIDTH-1:0] shifted;
      shifted = state >> 1;
      return state[0] ? (shifted ^ TG_LFSR_TAPS) : shifted;
   endfunction

endpackage

`default_nettype wire
